//--- build.f
hw/decomp_pkg.sv
hw/decomp_ctrl.sv
hw/decomp_round.sv
hw/decomp_balseq_core.sv
hw/decomp_level_collect.sv
hw/decomp_top.sv
verification/decomp_tb.sv

//--- hw/decomp_balseq_core.sv
// Balanced sequential decomposition core
`timescale 1ns/100ps

module decomp_balseq_core
  import decomp_pkg::*;
(
  input  logic              clk,
  input  logic              s_rst_n,
  input  logic [L*B_W-1:0]  in_data,
  input  logic              in_sign,
  input  logic              in_avail,
  input  logic [ID_W-1:0]   in_side,
  output logic [DIG_W-1:0]  out_data,
  output logic              out_avail,
  output logic              out_sol,
  output logic              out_eol,
  output logic [ID_W-1:0]   out_side
);

  // ------------------------------------------------------------------------
  // Sub-word shifter
  // ------------------------------------------------------------------------
  logic [L-1:0][B_W-1:0] s0_data;
  logic                  s0_sign;
  logic [ID_W-1:0]       s0_side;
  logic                  s0_run;
  logic [LVL_W-1:0]      s0_lvl;
  // One extra sub-word above the top, filled with the sign
  logic [L:0][B_W-1:0]   s0_data_ext;

  assign s0_data_ext = {{B_W{s0_sign}}, s0_data};

  // Load on avail, else shift down one level while running
  always_ff @(posedge clk) begin
    if (in_avail) begin
      s0_data <= in_data;
      s0_sign <= in_sign;
      s0_side <= in_side;
    end else if (s0_run) begin
      for (int i = 0; i < L; i++) begin
        s0_data[i] <= s0_data_ext[i+1];
      end
    end
  end

  // ------------------------------------------------------------------------
  // Level control
  // ------------------------------------------------------------------------
  logic s0_first_lvl;
  logic s0_last_lvl;

  assign s0_first_lvl = (s0_lvl == '0);
  assign s0_last_lvl  = (s0_lvl == LVL_W'(L - 1));

  // New load may land on the last level of the previous one
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      s0_run <= 1'b0;
      s0_lvl <= '0;
    end else if (in_avail) begin
      s0_run <= 1'b1;
      s0_lvl <= '0;
    end else if (s0_run) begin
      s0_run <= !s0_last_lvl;
      s0_lvl <= s0_lvl + 1'b1;
    end
  end

  // ------------------------------------------------------------------------
  // Digit computation
  // ------------------------------------------------------------------------
  logic [B_W-1:0] subw;
  logic           carry;
  logic           carry_q;
  logic [B_W:0]   subw_c;
  logic           gt_half;
  logic           ge_half;
  logic           overflow;
  logic           propagate;
  logic [B_W:0]   digit;

  assign subw = s0_data_ext[0];
  // No carry into level 0
  assign carry  = s0_first_lvl ? 1'b0 : carry_q;
  assign subw_c = {1'b0, subw} + carry;

  // Compare on the raw sub-word and carry, off the adder path
  assign gt_half  = subw[B_W-1] & |{subw[B_W-2:0], carry};
  assign ge_half  = subw[B_W-1] | &{subw[B_W-2:0], carry};
  assign overflow = &{subw, carry};

  // Tie at B/2 carries only when the next sub-word is negative
  // For the last level the sign extension plays that part
  assign propagate = overflow | gt_half | (ge_half & s0_data_ext[1][B_W-1]);

  // With a carry out the digit is subw_c - B
  assign digit = propagate ? {~subw_c[B_W], subw_c[B_W-1:0]} :
                             {1'b0, subw_c[B_W-1:0]};

  always_ff @(posedge clk) begin
    carry_q <= propagate;
  end

  // ------------------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    out_data <= digit;
    out_sol  <= s0_first_lvl;
    out_eol  <= s0_last_lvl;
    out_side <= s0_side;
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      out_avail <= 1'b0;
    end else begin
      out_avail <= s0_run;
    end
  end

endmodule

//--- hw/decomp_ctrl.sv
// Decomposition input control
`timescale 1ns/100ps

module decomp_ctrl
  import decomp_pkg::*;
(
  input  logic            clk,
  input  logic            s_rst_n,
  input  logic            coef_strobe,
  output logic            accept,
  output logic [ID_W-1:0] acc_id,
  output logic            ready,
  output logic            overrun
);

  // ------------------------------------------------------------------------
  // Acceptance
  // ------------------------------------------------------------------------
  // Cycles left before the core can take a new coefficient
  logic [LVL_W-1:0] hold_cnt;
  // Number given to the next accepted coefficient
  logic [ID_W-1:0]  id_cnt;

  // Ready as long as no hold is pending
  assign ready  = (hold_cnt == '0);
  assign accept = coef_strobe & ready;
  assign acc_id = id_cnt;

  // Hold ready low for L-1 cycles
  // Core takes the next load together with its last level
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      hold_cnt <= '0;
    end else if (accept) begin
      hold_cnt <= LVL_W'(L - 1);
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  // ------------------------------------------------------------------------
  // Numbering and overrun
  // ------------------------------------------------------------------------
  // Only accepted strobes take a number
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      id_cnt <= '0;
    end else if (accept) begin
      id_cnt <= id_cnt + 1'b1;
    end
  end

  // Sticky until reset
  // Strobe while busy means a lost coefficient
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      overrun <= 1'b0;
    end else if (coef_strobe && !ready) begin
      overrun <= 1'b1;
    end
  end

endmodule

//--- hw/decomp_level_collect.sv
// Level to word collector
`timescale 1ns/100ps

module decomp_level_collect
  import decomp_pkg::*;
(
  input  logic                      clk,
  input  logic                      s_rst_n,
  input  logic [DIG_W-1:0]          lvl_data,
  input  logic                      lvl_avail,
  input  logic                      lvl_sol,
  input  logic                      lvl_eol,
  input  logic [ID_W-1:0]           lvl_id,
  output logic [L-1:0][DIG_W-1:0]   word_digits,
  output logic [ID_W-1:0]           word_id,
  output logic                      word_valid
);

  logic [LVL_W-1:0]          lvl_idx;
  logic [LVL_W-1:0]          cur_idx;
  logic [L-1:0][DIG_W-1:0]   hold;
  logic [L-1:0][DIG_W-1:0]   hold_nxt;

  // Start of level restarts the slot index
  assign cur_idx = lvl_sol ? '0 : lvl_idx;

  // Current digit merged into the held ones
  always_comb begin
    hold_nxt = hold;
    for (int i = 0; i < L; i++) begin
      if (cur_idx == LVL_W'(i)) begin
        hold_nxt[i] = lvl_data;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (lvl_avail) begin
      hold <= hold_nxt;
    end
    // Publish the full word with the last level
    if (lvl_avail && lvl_eol) begin
      word_digits <= hold_nxt;
      word_id     <= lvl_id;
    end
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      lvl_idx    <= '0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= lvl_avail & lvl_eol;
      if (lvl_avail) begin
        lvl_idx <= cur_idx + 1'b1;
      end
    end
  end

endmodule

//--- hw/decomp_pkg.sv
// Gadget decomposition constants

package decomp_pkg;

  // Width of one input torus coefficient
  localparam int COEF_W = 32;

  // Bits per decomposition level
  // Base B is 2**B_W
  localparam int B_W = 8;

  // Number of decomposition levels
  localparam int L = 3;

  // Coefficient number width
  localparam int ID_W = 8;

  // Signed digit in two's complement
  localparam int DIG_W = B_W + 1;

  // Level counter width, at least one bit
  localparam int LVL_W = ($clog2(L) == 0) ? 1 : $clog2(L);

  // Rounding bit sits just below the kept field
  localparam int ROUND_POS = COEF_W - L * B_W - 1;

endpackage

//--- hw/decomp_round.sv
// Closest representable rounding stage
`timescale 1ns/100ps

module decomp_round
  import decomp_pkg::*;
(
  input  logic                 clk,
  input  logic                 s_rst_n,
  input  logic                 accept,
  input  logic [ID_W-1:0]      acc_id,
  input  logic [COEF_W-1:0]    coef_in,
  output logic [L*B_W-1:0]     rnd_data,
  output logic                 rnd_sign,
  output logic                 rnd_avail,
  output logic [ID_W-1:0]      rnd_id
);

  // ------------------------------------------------------------------------
  // Rounding
  // ------------------------------------------------------------------------
  // Coefficient plus half an LSB of the kept field
  logic [COEF_W-1:0] coef_rnd;
  // Top L*B_W bits of the rounded value
  logic [L*B_W-1:0]  coef_keep;

  // Wraps modulo 2**COEF_W
  // Top of the torus folds back to zero
  assign coef_rnd  = coef_in + (COEF_W'(1) << ROUND_POS);
  assign coef_keep = coef_rnd[COEF_W-1 -: L*B_W];

  // ------------------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------------------
  // Payload loads on accept only
  always_ff @(posedge clk) begin
    if (accept) begin
      rnd_data <= coef_keep;
      // Top kept bit gives the sign of the closest rep
      rnd_sign <= coef_keep[L*B_W-1];
      rnd_id   <= acc_id;
    end
  end

  // One cycle avail pulse per accepted coefficient
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      rnd_avail <= 1'b0;
    end else begin
      rnd_avail <= accept;
    end
  end

endmodule

//--- hw/decomp_top.sv
// Gadget decomposition front end
`timescale 1ns/100ps

module decomp_top
  import decomp_pkg::*;
(
  input  logic                    clk,
  input  logic                    s_rst_n,
  input  logic [COEF_W-1:0]       coef_in,
  input  logic                    coef_strobe,
  output logic [DIG_W-1:0]        lvl_data,
  output logic                    lvl_avail,
  output logic                    lvl_sol,
  output logic                    lvl_eol,
  output logic [ID_W-1:0]         lvl_id,
  output logic [L*DIG_W-1:0]      word_digits,
  output logic [ID_W-1:0]         word_id,
  output logic                    word_valid,
  output logic                    ready,
  output logic                    overrun
);

  // Control to rounding
  logic             accept;
  logic [ID_W-1:0]  acc_id;
  // Rounding to core
  logic [L*B_W-1:0] rnd_data;
  logic             rnd_sign;
  logic             rnd_avail;
  logic [ID_W-1:0]  rnd_id;

  decomp_ctrl u_ctrl (
    .clk         (clk),
    .s_rst_n     (s_rst_n),
    .coef_strobe (coef_strobe),
    .accept      (accept),
    .acc_id      (acc_id),
    .ready       (ready),
    .overrun     (overrun)
  );

  decomp_round u_round (
    .clk       (clk),
    .s_rst_n   (s_rst_n),
    .accept    (accept),
    .acc_id    (acc_id),
    .coef_in   (coef_in),
    .rnd_data  (rnd_data),
    .rnd_sign  (rnd_sign),
    .rnd_avail (rnd_avail),
    .rnd_id    (rnd_id)
  );

  // Level stream leaves the top and also feeds the collector
  decomp_balseq_core u_core (
    .clk       (clk),
    .s_rst_n   (s_rst_n),
    .in_data   (rnd_data),
    .in_sign   (rnd_sign),
    .in_avail  (rnd_avail),
    .in_side   (rnd_id),
    .out_data  (lvl_data),
    .out_avail (lvl_avail),
    .out_sol   (lvl_sol),
    .out_eol   (lvl_eol),
    .out_side  (lvl_id)
  );

  decomp_level_collect u_collect (
    .clk         (clk),
    .s_rst_n     (s_rst_n),
    .lvl_data    (lvl_data),
    .lvl_avail   (lvl_avail),
    .lvl_sol     (lvl_sol),
    .lvl_eol     (lvl_eol),
    .lvl_id      (lvl_id),
    .word_digits (word_digits),
    .word_id     (word_id),
    .word_valid  (word_valid)
  );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the decomposition testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module decomp_tb -f build.f -o decomp_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/decomp_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Verdict comes from the log
if grep -q "Test FAILED" "$LOG"; then
  exit 1
fi
exit 0

//--- verification/decomp_stimulus.txt
// coefficient (hex), then expected digits of level 0, 1, 2 (signed decimal)
// level 0 is the least significant digit, every digit in -128..128
00000000 0 0 0
00000080 1 0 0
0000007F 0 0 0
12345678 86 52 18
FFFFFF80 0 0 0
FFFFFF00 -1 0 0
00008000 128 0 0
00808000 -128 -127 1
80000000 0 0 -128
7FFF8000 -128 0 128
C0000000 0 0 -64
DEADBEEF -65 -82 -33
017F7F7F 127 127 1
00FF7F80 -128 0 1
7FFFFFFF 0 0 -128
55AA3380 52 -86 86
80FF0000 0 -1 -127
3F80FF7F -1 -127 64
00007F80 128 0 0

//--- verification/decomp_tb.sv
// Decomposition front end testbench
`timescale 1ns/100ps

module decomp_tb
  import decomp_pkg::*;
();

  localparam int MAX_ENT     = 64;
  // Entries from here on go in at full rate
  localparam int FULL_START  = 12;
  // Extra strobe right after this entry is accepted
  localparam int DROP_AT     = 7;
  localparam int OUT_TIMEOUT = 32;
  localparam int RDY_TIMEOUT = 16;

  logic                 clk;
  logic                 s_rst_n;
  logic [COEF_W-1:0]    coef_in;
  logic                 coef_strobe;
  logic [DIG_W-1:0]     lvl_data;
  logic                 lvl_avail;
  logic                 lvl_sol;
  logic                 lvl_eol;
  logic [ID_W-1:0]      lvl_id;
  logic [L*DIG_W-1:0]   word_digits;
  logic [ID_W-1:0]      word_id;
  logic                 word_valid;
  logic                 ready;
  logic                 overrun;

  // File entries
  logic [COEF_W-1:0] coef_a [0:MAX_ENT-1];
  int                dig_a  [0:MAX_ENT-1][0:L-1];
  int                acc_cyc [0:MAX_ENT-1];
  int                n_ent;
  // Accepted entries waiting for their output
  int                lvl_q[$];
  int                word_q[$];

  int          cyc;
  logic [15:0] lfsr;
  bit          hung;
  int          n_chk [1:6];
  int          n_err [1:6];
  string       test_name [1:6];

  decomp_top dut0 (
    .clk(clk), .s_rst_n(s_rst_n), .coef_in(coef_in), .coef_strobe(coef_strobe),
    .lvl_data(lvl_data), .lvl_avail(lvl_avail), .lvl_sol(lvl_sol), .lvl_eol(lvl_eol),
    .lvl_id(lvl_id), .word_digits(word_digits), .word_id(word_id),
    .word_valid(word_valid), .ready(ready), .overrun(overrun)
  );

  always #5 clk = ~clk;

  // Cycle count for latency
  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // Top L*B_W bits after adding half an LSB, modulo 2**COEF_W
  function automatic longint rounded_value(input logic [COEF_W-1:0] c);
    logic [COEF_W-1:0] sum;
    sum = c + (COEF_W'(1) << (COEF_W - L * B_W - 1));
    return longint'(sum >> (COEF_W - L * B_W));
  endfunction

  task automatic check_val(input int t, input string name, input longint exp,
                           input longint got);
    n_chk[t]++;
    assert (got == exp) else begin
      $display("Fail at %0t: %s expected %0d got %0d", $time, name, exp, got);
      n_err[t]++;
    end
  endtask

  task automatic check_cond(input int t, input bit ok, input string what);
    n_chk[t]++;
    assert (ok) else begin
      $display("Error at %0t: %s", $time, what);
      n_err[t]++;
    end
  endtask

  // One result line per test
  task automatic report_test(input int t);
    $display("test %0d %s: %s, %0d checks, %0d failed", t, test_name[t],
             (n_err[t] == 0) ? "pass" : "fail", n_chk[t], n_err[t]);
  endtask

  task automatic load_stimulus();
    int    fd;
    int    cnt;
    string line;
    logic [COEF_W-1:0] c;
    int    d0;
    int    d1;
    int    d2;
    n_ent = 0;
    fd = $fopen("verification/decomp_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Error: the stimulus file could not be opened");
      hung = 1'b1;
      return;
    end
    while (!$feof(fd) && n_ent < MAX_ENT) begin
      line = "";
      cnt = $fgets(line, fd);
      // Comment and blank lines do not scan
      if (cnt > 0 && $sscanf(line, "%h %d %d %d", c, d0, d1, d2) == 4) begin
        coef_a[n_ent]   = c;
        dig_a[n_ent][0] = d0;
        dig_a[n_ent][1] = d1;
        dig_a[n_ent][2] = d2;
        n_ent++;
      end
    end
    $fclose(fd);
  endtask

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  task automatic drive_stream();
    int gap;
    int tries;
    for (int n = 0; n < n_ent; n++) begin
      tries = 0;
      while (!ready && tries < RDY_TIMEOUT) begin
        @(negedge clk);
        tries++;
      end
      if (!ready) begin
        $display("Timeout: ready stayed low before coefficient %0d", n);
        hung = 1'b1;
        return;
      end
      // Two LFSR bits give the idle gap
      gap = 0;
      if (n < FULL_START) begin
        for (int b = 0; b < 2; b++) begin
          lfsr = lfsr_step(lfsr);
          gap = gap * 2 + int'(lfsr[0]);
        end
      end
      repeat (gap) @(negedge clk);
      coef_in     = coef_a[n];
      coef_strobe = 1'b1;
      acc_cyc[n]  = cyc + 1;
      lvl_q.push_back(n);
      word_q.push_back(n);
      if (n <= DROP_AT) begin
        check_val(6, "overrun", 0, longint'(overrun));
      end
      if (n > FULL_START) begin
        check_val(5, "accept spacing", L, acc_cyc[n] - acc_cyc[n-1]);
      end
      @(negedge clk);
      coef_strobe = 1'b0;
      if (n == DROP_AT) begin
        // Busy core, this one must be dropped
        check_cond(6, !ready, "ready was high when the dropped strobe came");
        coef_in     = 32'hAAAA_AAAA;
        coef_strobe = 1'b1;
        @(negedge clk);
        coef_strobe = 1'b0;
        check_val(6, "overrun", 1, longint'(overrun));
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // Monitors
  // --------------------------------------------------------------------------
  task automatic watch_levels();
    int     tries;
    int     n;
    int     d;
    int     t;
    longint recomp;
    for (int k = 0; k < n_ent; k++) begin
      recomp = 0;
      n = k;
      for (int i = 0; i < L; i++) begin
        @(negedge clk);
        tries = 0;
        while (!lvl_avail && tries < OUT_TIMEOUT) begin
          @(negedge clk);
          tries++;
        end
        if (!lvl_avail) begin
          $display("Timeout: level %0d of coefficient %0d never came", i, k);
          hung = 1'b1;
          return;
        end
        if (i == 0) begin
          check_cond(2, lvl_q.size() != 0, "level output with no coefficient pending");
          n = (lvl_q.size() != 0) ? lvl_q.pop_front() : k;
        end
        t = (n >= FULL_START) ? 5 : 2;
        d = int'($signed(lvl_data));
        check_val(t, "lvl_data", dig_a[n][i], d);
        check_cond(2, d >= -(1 << (B_W - 1)) && d <= (1 << (B_W - 1)),
                   "digit outside -B/2..B/2");
        check_val(3, "lvl_sol", (i == 0), longint'(lvl_sol));
        check_val(3, "lvl_eol", (i == L - 1), longint'(lvl_eol));
        check_val(3, "lvl_id", k % (1 << ID_W), longint'(lvl_id));
        recomp = recomp + longint'(d) * (longint'(1) << (B_W * i));
      end
      recomp = recomp & ((longint'(1) << (L * B_W)) - 1);
      check_val(2, "recomposed value", rounded_value(coef_a[n]), recomp);
    end
  endtask

  task automatic watch_words();
    int tries;
    int n;
    for (int k = 0; k < n_ent; k++) begin
      @(negedge clk);
      tries = 0;
      while (!word_valid && tries < OUT_TIMEOUT) begin
        @(negedge clk);
        tries++;
      end
      if (!word_valid) begin
        $display("Timeout: word of coefficient %0d never came", k);
        hung = 1'b1;
        return;
      end
      check_cond(4, word_q.size() != 0, "word output with no coefficient pending");
      n = (word_q.size() != 0) ? word_q.pop_front() : k;
      for (int i = 0; i < L; i++) begin
        check_val(4, $sformatf("word_digits[%0d]", i), dig_a[n][i],
                  longint'($signed(word_digits[i*DIG_W +: DIG_W])));
      end
      check_val(4, "word_id", k % (1 << ID_W), longint'(word_id));
      check_val(4, "word_valid latency", L + 2, cyc - acc_cyc[n]);
    end
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    int total_err;
    clk         = 1'b0;
    s_rst_n     = 1'b0;
    coef_in     = '0;
    coef_strobe = 1'b0;
    cyc         = 0;
    lfsr        = 16'd21210;
    hung        = 1'b0;
    total_err   = 0;
    test_name = '{"idle after reset", "digits and recomposition", "framing",
                  "collected word", "full rate", "overrun and drop"};
    for (int t = 1; t <= 6; t++) begin
      n_chk[t] = 0;
      n_err[t] = 0;
    end
    load_stimulus();

    repeat (3) @(posedge clk);
    @(negedge clk);
    s_rst_n = 1'b1;

    // Quiet outputs with no strobe
    repeat (5) begin
      @(negedge clk);
      check_val(1, "ready", 1, longint'(ready));
      check_val(1, "lvl_avail", 0, longint'(lvl_avail));
      check_val(1, "word_valid", 0, longint'(word_valid));
      check_val(1, "overrun", 0, longint'(overrun));
    end
    report_test(1);

    if (!hung) begin
      fork
        drive_stream();
        watch_levels();
        watch_words();
      join
    end
    for (int t = 2; t <= 5; t++) begin
      report_test(t);
    end

    // Nothing left over from the dropped coefficient
    repeat (8) begin
      @(negedge clk);
      check_cond(6, !lvl_avail && !word_valid, "output after the last coefficient");
    end
    check_val(6, "overrun", 1, longint'(overrun));
    report_test(6);

    for (int t = 1; t <= 6; t++) begin
      total_err += n_err[t];
    end
    $display("Summary: %0d coefficients, %0d errors", n_ent, total_err);
    if (!hung && n_ent > 0 && total_err == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
